// ==== src/softshrink_pkg.sv ====
package softshrink_pkg;

  // element formats, input is Q4.4 and output is Q3.2
  localparam int DATA_WIDTH     = 8;
  localparam int FRAC_WIDTH     = 4;
  localparam int OUT_WIDTH      = 5;
  localparam int OUT_FRAC_WIDTH = 2;

  // lanes per beat on each side of the roller
  localparam int IN_LANES    = 4;
  localparam int OUT_LANES   = 2;
  localparam int ROLL_CHUNKS = IN_LANES / OUT_LANES;
  localparam int CHUNK_WIDTH = $clog2(ROLL_CHUNKS);

  // input FIFO geometry in whole beats
  localparam int FIFO_DEPTH  = 4;
  localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // 0.5 scaled by 2^FRAC_WIDTH
  localparam logic signed [DATA_WIDTH-1:0] FX_LAMBDA = 8;

  // rounding drops this many fraction bits and keeps the rest of the word
  localparam int FRAC_DROP  = FRAC_WIDTH - OUT_FRAC_WIDTH;
  localparam int KEEP_WIDTH = DATA_WIDTH - FRAC_DROP;

  // saturation limits of the output word
  localparam logic signed [OUT_WIDTH-1:0] OUT_MAX = {1'b0, {(OUT_WIDTH-1){1'b1}}};
  localparam logic signed [OUT_WIDTH-1:0] OUT_MIN = {1'b1, {(OUT_WIDTH-1){1'b0}}};

  typedef struct packed {
    logic [DATA_WIDTH-FRAC_WIDTH-1:0] int_part;
    logic [FRAC_WIDTH-1:0]            frac_part;
  } fx_fields_t;

  // one element seen either as a signed number or split at the binary point
  typedef union packed {
    logic signed [DATA_WIDTH-1:0] raw;
    fx_fields_t                   fields;
  } fx_word_t;

endpackage

// ==== src/unpacked_fifo.sv ====
`timescale 1ns/1ps

module unpacked_fifo (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [softshrink_pkg::DATA_WIDTH-1:0] data_in [softshrink_pkg::IN_LANES],
  input  logic                               in_valid,
  output logic                               in_ready,
  output logic [softshrink_pkg::DATA_WIDTH-1:0] data_out [softshrink_pkg::IN_LANES],
  output logic                               out_valid,
  input  logic                               out_ready
);

  logic [softshrink_pkg::DATA_WIDTH-1:0] mem [softshrink_pkg::FIFO_DEPTH][softshrink_pkg::IN_LANES];

  logic [softshrink_pkg::PTR_WIDTH-1:0]   wr_ptr;
  logic [softshrink_pkg::PTR_WIDTH-1:0]   rd_ptr;
  logic [softshrink_pkg::COUNT_WIDTH-1:0] count;

  logic wr_en;
  logic rd_en;
  logic wr_last;
  logic rd_last;

  assign in_ready  = (count != softshrink_pkg::COUNT_WIDTH'(softshrink_pkg::FIFO_DEPTH));
  assign out_valid = (count != '0);

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // pointers wrap explicitly so the depth need not be a power of two
  assign wr_last = (wr_ptr == softshrink_pkg::PTR_WIDTH'(softshrink_pkg::FIFO_DEPTH - 1));
  assign rd_last = (rd_ptr == softshrink_pkg::PTR_WIDTH'(softshrink_pkg::FIFO_DEPTH - 1));

  // show-ahead, the head beat is always on the output
  assign data_out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
    end
  end

  // a simultaneous read and write leaves the occupancy unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// ==== src/roller.sv ====
`timescale 1ns/1ps

module roller (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [softshrink_pkg::DATA_WIDTH-1:0] data_in [softshrink_pkg::IN_LANES],
  input  logic                               in_valid,
  output logic                               in_ready,
  output logic [softshrink_pkg::DATA_WIDTH-1:0] data_out [softshrink_pkg::OUT_LANES],
  output logic                               out_valid,
  input  logic                               out_ready
);

  logic [softshrink_pkg::DATA_WIDTH-1:0]  beat_q [softshrink_pkg::IN_LANES];
  logic [softshrink_pkg::CHUNK_WIDTH-1:0] chunk_q;
  logic                                   full_q;

  logic last_chunk;
  logic in_fire;
  logic out_fire;

  assign last_chunk = (chunk_q == softshrink_pkg::CHUNK_WIDTH'(softshrink_pkg::ROLL_CHUNKS - 1));

  assign out_valid = full_q;
  assign out_fire  = full_q && out_ready;

  // a new beat can land in the same cycle the last chunk leaves
  assign in_ready = !full_q || (out_ready && last_chunk);
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (in_fire) begin
      beat_q <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q  <= 1'b0;
      chunk_q <= '0;
    end else if (in_fire) begin
      full_q  <= 1'b1;
      chunk_q <= '0;
    end else if (out_fire) begin
      if (last_chunk) begin
        full_q  <= 1'b0;
        chunk_q <= '0;
      end else begin
        chunk_q <= chunk_q + 1'b1;
      end
    end
  end

  // chunk n carries lanes n*OUT_LANES upward, lower lanes go first
  always_comb begin
    for (int j = 0; j < softshrink_pkg::OUT_LANES; j++) begin
      data_out[j] = beat_q[int'(chunk_q) * softshrink_pkg::OUT_LANES + j];
    end
  end

endmodule

// ==== src/fixed_rounding.sv ====
`timescale 1ns/1ps

module fixed_rounding (
  input  softshrink_pkg::fx_word_t             data_in  [softshrink_pkg::OUT_LANES],
  output logic [softshrink_pkg::OUT_WIDTH-1:0] data_out [softshrink_pkg::OUT_LANES]
);

  logic [softshrink_pkg::KEEP_WIDTH-1:0]      kept     [softshrink_pkg::OUT_LANES];
  logic                                       round_up [softshrink_pkg::OUT_LANES];
  logic signed [softshrink_pkg::KEEP_WIDTH:0] sum      [softshrink_pkg::OUT_LANES];

  always_comb begin
    for (int i = 0; i < softshrink_pkg::OUT_LANES; i++) begin
      // integer part plus the fraction bits that survive, this is floor(x/4)
      kept[i] = {data_in[i].fields.int_part,
                 data_in[i].fields.frac_part[softshrink_pkg::FRAC_WIDTH-1 -:
                                             softshrink_pkg::OUT_FRAC_WIDTH]};

      // highest dropped bit is the half step, adding it rounds half up
      round_up[i] = data_in[i].fields.frac_part[softshrink_pkg::FRAC_DROP-1];

      // one extra bit so +31 plus the round bit cannot wrap
      sum[i] = {kept[i][softshrink_pkg::KEEP_WIDTH-1], kept[i]} +
               {{softshrink_pkg::KEEP_WIDTH{1'b0}}, round_up[i]};

      if (sum[i] > softshrink_pkg::OUT_MAX) begin
        data_out[i] = softshrink_pkg::OUT_MAX;
      end else if (sum[i] < softshrink_pkg::OUT_MIN) begin
        data_out[i] = softshrink_pkg::OUT_MIN;
      end else begin
        data_out[i] = sum[i][softshrink_pkg::OUT_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== src/unpacked_register_slice.sv ====
`timescale 1ns/1ps

module unpacked_register_slice (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [softshrink_pkg::OUT_WIDTH-1:0] in_data [softshrink_pkg::OUT_LANES],
  input  logic                              in_valid,
  output logic                              in_ready,
  output logic [softshrink_pkg::OUT_WIDTH-1:0] out_data [softshrink_pkg::OUT_LANES],
  output logic                              out_valid,
  input  logic                              out_ready
);

  logic [softshrink_pkg::OUT_WIDTH-1:0] main_data [softshrink_pkg::OUT_LANES];
  logic [softshrink_pkg::OUT_WIDTH-1:0] skid_data [softshrink_pkg::OUT_LANES];
  logic                                 main_valid;
  logic                                 skid_valid;

  logic in_fire;

  // ready comes straight from a flop, out_ready never reaches the roller
  assign in_ready  = !skid_valid;
  assign in_fire   = in_valid && in_ready;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (skid_valid) begin
      // drain the skid entry into main, input is blocked meanwhile
      if (out_ready) begin
        skid_valid <= 1'b0;
      end
    end else if (in_fire) begin
      if (main_valid && !out_ready) begin
        skid_valid <= 1'b1;
      end else begin
        main_valid <= 1'b1;
      end
    end else if (out_ready) begin
      main_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_valid) begin
      if (out_ready) begin
        main_data <= skid_data;
      end
    end else if (in_fire) begin
      if (main_valid && !out_ready) begin
        skid_data <= in_data;
      end else begin
        main_data <= in_data;
      end
    end
  end

endmodule

// ==== src/fixed_softshrink.sv ====
`timescale 1ns/1ps

module fixed_softshrink (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [softshrink_pkg::DATA_WIDTH-1:0] data_in [softshrink_pkg::IN_LANES],
  input  logic                                  data_in_valid,
  output logic                                  data_in_ready,
  output logic [softshrink_pkg::OUT_WIDTH-1:0]  data_out [softshrink_pkg::OUT_LANES],
  output logic                                  data_out_valid,
  input  logic                                  data_out_ready
);

  logic [softshrink_pkg::DATA_WIDTH-1:0] ff_data   [softshrink_pkg::IN_LANES];
  logic [softshrink_pkg::DATA_WIDTH-1:0] roll_data [softshrink_pkg::OUT_LANES];
  logic [softshrink_pkg::OUT_WIDTH-1:0]  rnd_data  [softshrink_pkg::OUT_LANES];
  softshrink_pkg::fx_word_t              shrunk    [softshrink_pkg::OUT_LANES];

  logic ff_valid;
  logic ff_ready;
  logic roll_valid;
  logic roll_ready;

  unpacked_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (data_in),
    .in_valid  (data_in_valid),
    .in_ready  (data_in_ready),
    .data_out  (ff_data),
    .out_valid (ff_valid),
    .out_ready (ff_ready)
  );

  roller u_roller (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (ff_data),
    .in_valid  (ff_valid),
    .in_ready  (ff_ready),
    .data_out  (roll_data),
    .out_valid (roll_valid),
    .out_ready (roll_ready)
  );

  // shrink each lane toward zero by lambda, the dead band maps to zero
  for (genvar i = 0; i < softshrink_pkg::OUT_LANES; i++) begin : g_shrink
    softshrink_pkg::fx_word_t lane;

    assign lane.raw = roll_data[i];

    always_comb begin
      if (lane.raw < -softshrink_pkg::FX_LAMBDA) begin
        shrunk[i].raw = lane.raw + softshrink_pkg::FX_LAMBDA;
      end else if (lane.raw > softshrink_pkg::FX_LAMBDA) begin
        shrunk[i].raw = lane.raw - softshrink_pkg::FX_LAMBDA;
      end else begin
        shrunk[i].raw = '0;
      end
    end
  end

  fixed_rounding u_rounding (
    .data_in  (shrunk),
    .data_out (rnd_data)
  );

  unpacked_register_slice u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (rnd_data),
    .in_valid  (roll_valid),
    .in_ready  (roll_ready),
    .out_data  (data_out),
    .out_valid (data_out_valid),
    .out_ready (data_out_ready)
  );

endmodule

// ==== verification/tb_fixed_softshrink.sv ====
`timescale 1ns/1ps

module tb_fixed_softshrink;

  localparam int CLK_PERIOD = 40;
  localparam int LANES_IN   = softshrink_pkg::IN_LANES;
  localparam int LANES_OUT  = softshrink_pkg::OUT_LANES;
  localparam int DW         = softshrink_pkg::DATA_WIDTH;
  localparam int OW         = softshrink_pkg::OUT_WIDTH;

  // threshold 0.5 in Q4.4 and the range of a Q3.2 output word
  localparam int LAMBDA_RAW = 8;
  localparam int OUT_LO     = -16;
  localparam int OUT_HI     = 15;

  // the watchdog is sized from this upper bound on input beats over all tests
  localparam int TOTAL_BEATS = 80;
  localparam int WAIT_LIMIT  = 300;

  logic          clk = 1'b0;
  logic          rst_n;
  logic [DW-1:0] data_in [LANES_IN];
  logic          data_in_valid;
  logic          data_in_ready;
  logic [OW-1:0] data_out [LANES_OUT];
  logic          data_out_valid;
  logic          data_out_ready;

  logic [OW-1:0] expected_q [$];
  logic [OW-1:0] held_data [LANES_OUT];
  logic [OW-1:0] exp_val;
  logic          held_valid;
  logic          ready_random;
  int            beats_in;
  int            beats_out;

  fixed_softshrink dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s at %0t: got 0x%02h, expected 0x%02h", name, $time, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // shrink toward zero, round half up to a quarter and then saturate
  function automatic logic [OW-1:0] model_out(input logic [DW-1:0] x);
    int xi;
    int s;
    int r;
    xi = $signed(x);
    if (xi < -LAMBDA_RAW) begin
      s = xi + LAMBDA_RAW;
    end else if (xi > LAMBDA_RAW) begin
      s = xi - LAMBDA_RAW;
    end else begin
      s = 0;
    end
    r = (s + 2) >>> 2;
    if (r > OUT_HI) begin
      r = OUT_HI;
    end else if (r < OUT_LO) begin
      r = OUT_LO;
    end
    return OW'(r);
  endfunction

  function automatic logic [31:0] pack_beat(input int a, input int b, input int c, input int d);
    return {8'(d), 8'(c), 8'(b), 8'(a)};
  endfunction

  task automatic tick();
    @(posedge clk);
    if (ready_random) begin
      data_out_ready <= ($urandom_range(0, 1) == 1);
    end
  endtask

  task automatic drive_beat(input logic [31:0] beat);
    for (int i = 0; i < LANES_IN; i++) begin
      data_in[i] <= beat[8*i +: 8];
      expected_q.push_back(model_out(beat[8*i +: 8]));
    end
    data_in_valid <= 1'b1;
  endtask

  // returns on the edge where the beat was taken
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    tick();
    while (!data_in_ready && cycles < WAIT_LIMIT) begin
      tick();
      cycles++;
    end
    if (!data_in_ready) begin
      fail_run("input beat was never accepted");
    end
    beats_in++;
  endtask

  task automatic send_beat(input logic [31:0] beat);
    drive_beat(beat);
    wait_accept();
  endtask

  task automatic go_idle();
    data_in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
      tick();
      cycles++;
    end
    if (expected_q.size() != 0) begin
      fail_run("expected output elements never arrived");
    end
    // a few idle cycles so a stray extra beat would be seen
    repeat (4) tick();
  endtask

  // scoreboard and hold check run on every edge with the values from before it
  always @(posedge clk) begin
    if (!rst_n) begin
      held_valid = 1'b0;
    end else begin
      if (held_valid) begin
        check_value("data_out_valid", 8'(data_out_valid), 8'h01);
        for (int j = 0; j < LANES_OUT; j++) begin
          check_value($sformatf("data_out[%0d]", j), 8'(data_out[j]), 8'(held_data[j]));
        end
      end
      if (data_out_valid && data_out_ready) begin
        if (expected_q.size() < LANES_OUT) begin
          fail_run("an output beat arrived with no data expected");
        end else begin
          for (int j = 0; j < LANES_OUT; j++) begin
            exp_val = expected_q.pop_front();
            check_value($sformatf("data_out[%0d]", j), 8'(data_out[j]), 8'(exp_val));
          end
          beats_out++;
        end
      end
      held_valid = data_out_valid && !data_out_ready;
      held_data  = data_out;
    end
  end

  task automatic test_reset();
    repeat (4) begin
      tick();
      check_value("data_out_valid", 8'(data_out_valid), 8'h00);
    end
    rst_n <= 1'b1;
    tick();
    check_value("data_in_ready", 8'(data_in_ready), 8'h01);
    check_value("data_out_valid", 8'(data_out_valid), 8'h00);
  endtask

  task automatic test_threshold();
    data_out_ready <= 1'b1;
    send_beat(pack_beat(-9, -8, -1, 0));
    send_beat(pack_beat(8, 9, 20, -20));
    go_idle();
    wait_drain();
  endtask

  task automatic test_rounding();
    send_beat(pack_beat(10, 11, 13, -14));
    send_beat(pack_beat(12, -13, 14, -15));
    send_beat(pack_beat(127, -127, -128, -10));
    go_idle();
    wait_drain();
  endtask

  task automatic test_lane_order();
    repeat (16) begin
      send_beat($urandom());
    end
    go_idle();
    wait_drain();
  endtask

  task automatic test_backpressure();
    int accepted;
    accepted = 0;
    data_out_ready <= 1'b0;
    drive_beat($urandom());
    tick();
    while (data_in_ready && accepted < 16) begin
      accepted++;
      beats_in++;
      drive_beat($urandom());
      tick();
    end
    if (data_in_ready) begin
      fail_run("data_in_ready never fell while data_out_ready was held low");
    end
    // the last driven beat is still pending and stays on the bus
    ready_random = 1'b1;
    wait_accept();
    repeat (32) begin
      send_beat($urandom());
    end
    go_idle();
    wait_drain();
    ready_random = 1'b0;
    data_out_ready <= 1'b1;
  endtask

  initial begin
    #(CLK_PERIOD * (TOTAL_BEATS * 8 + 200));
    $display("simulation timed out before the tests finished");
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(62));
    rst_n          = 1'b0;
    data_in_valid  = 1'b0;
    data_out_ready = 1'b0;
    ready_random   = 1'b0;
    held_valid     = 1'b0;
    beats_in       = 0;
    beats_out      = 0;
    for (int i = 0; i < LANES_IN; i++) begin
      data_in[i] = '0;
    end

    test_reset();
    test_threshold();
    test_rounding();
    test_lane_order();
    test_backpressure();

    if (expected_q.size() == 0 && beats_out == beats_in * (LANES_IN / LANES_OUT)) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run("output beat count does not match the input beats");
    end
  end

endmodule

// ==== files.f ====
src/softshrink_pkg.sv
src/unpacked_fifo.sv
src/roller.sv
src/fixed_rounding.sv
src/unpacked_register_slice.sv
src/fixed_softshrink.sv
verification/tb_fixed_softshrink.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fixed_softshrink \
  -f files.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'Result: PASSED'; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
